// ==== Bender.yml ====
package:
  name: branch_frontend

sources:
  - rtl/fe_pkg.sv
  - rtl/fetch_unit.sv
  - rtl/fetch_queue.sv
  - rtl/branch_unit.sv
  - rtl/branch_frontend.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_branch_frontend.sv

// ==== bench/frontend_model.svh ====
`ifndef FRONTEND_MODEL_SVH
`define FRONTEND_MODEL_SVH

// Branch kinds of the architectural model
localparam int K_NONE  = 0;
localparam int K_B     = 1;
localparam int K_BEQZ  = 2;
localparam int K_BNEZ  = 3;
localparam int K_BTEQZ = 4;
localparam int K_BTNEZ = 5;
localparam int K_JR    = 6;
localparam int K_JALR  = 7;
localparam int K_JRRA  = 8;

function automatic int decode_kind(input logic [fe_pkg::XLEN-1:0] word);
	fe_pkg::instr_u ins;
	ins = word;
	case (ins.lng.op)
		fe_pkg::OP_B:    return K_B;
		fe_pkg::OP_BEQZ: return K_BEQZ;
		fe_pkg::OP_BNEZ: return K_BNEZ;
		fe_pkg::OP_TBR: begin
			if (ins.rbr.rx == fe_pkg::TBR_EQZ) return K_BTEQZ;
			if (ins.rbr.rx == fe_pkg::TBR_NEZ) return K_BTNEZ;
		end
		fe_pkg::OP_JREG: begin
			if (ins.rjmp.funct11 == fe_pkg::FN_JRRA) return K_JRRA;
			if (ins.rjmp.funct11[7:0] == fe_pkg::FN_JR) return K_JR;
			if (ins.rjmp.funct11[7:0] == fe_pkg::FN_JALR) return K_JALR;
		end
		default: ;
	endcase
	return K_NONE;  // Other encodings only retire
endfunction

function automatic logic [fe_pkg::SEL_W-1:0] operand_sel(input int kind,
		input logic [fe_pkg::XLEN-1:0] word);
	fe_pkg::instr_u ins;
	ins = word;
	case (kind)
		K_BEQZ, K_BNEZ, K_JR, K_JALR: return {1'b0, ins.rbr.rx};
		K_BTEQZ, K_BTNEZ: return fe_pkg::REG_T;
		K_JRRA: return fe_pkg::REG_RA;
		default: return '0;
	endcase
endfunction

function automatic logic is_taken(input int kind, input logic [fe_pkg::XLEN-1:0] operand);
	case (kind)
		K_B, K_JR, K_JALR, K_JRRA: return 1'b1;
		K_BEQZ, K_BTEQZ: return operand == '0;
		K_BNEZ, K_BTNEZ: return operand != '0;
		default: return 1'b0;
	endcase
endfunction

function automatic logic [fe_pkg::XLEN-1:0] branch_target(input int kind,
		input logic [fe_pkg::XLEN-1:0] pc, input logic [fe_pkg::XLEN-1:0] word,
		input logic [fe_pkg::XLEN-1:0] operand);
	logic [fe_pkg::XLEN-1:0] step;
	step = pc + 16'd1;
	case (kind)
		K_B: return step + {{5{word[10]}}, word[10:0]};
		K_JR, K_JALR, K_JRRA: return operand;
		default: return step + {{8{word[7]}}, word[7:0]};  // Short conditional offset
	endcase
endfunction

`endif

// ==== bench/tb_branch_frontend.sv ====
`timescale 1ns/1ps

module tb_branch_frontend;

	localparam int QUEUE_DEPTH  = 4;
	localparam int MEM_WORDS    = 64;
	localparam int HALF_RETIRES = 300;
	localparam int ALL_RETIRES  = 600;
	localparam int CYCLE_LIMIT  = ALL_RETIRES * 10;

	logic                     clk;
	logic                     arst_n;
	logic                     imem_req;
	logic [fe_pkg::XLEN-1:0]  imem_addr;
	logic [fe_pkg::XLEN-1:0]  imem_data;
	logic [fe_pkg::SEL_W-1:0] rd_sel;
	logic [fe_pkg::XLEN-1:0]  rd_data;
	logic                     ra_we;
	logic [fe_pkg::XLEN-1:0]  ra_data;
	logic                     retire_valid;
	logic [fe_pkg::XLEN-1:0]  retire_pc;
	logic [fe_pkg::XLEN-1:0]  retire_instr;
	logic                     retire_ready;
	logic                     redirect;
	logic [fe_pkg::XLEN-1:0]  redirect_pc;

	logic [fe_pkg::XLEN-1:0]  mem [MEM_WORDS];
	logic [fe_pkg::XLEN-1:0]  regs [16];  // Register file seen by the DUT
	logic [fe_pkg::XLEN-1:0]  m_regs [16];  // Architectural copy
	logic [fe_pkg::XLEN-1:0]  m_pc;
	logic [31:0]              lcg_state;
	logic [31:0]              bp_word;
	logic                     backpressure;
	logic                     prev_hold;
	int                       cycles;
	int                       retired;
	int                       errors;
	int                       errors_at_start;
	int                       tests_run;
	int                       tests_failed;
	int                       redirects;
	int                       ra_writes;

	`include "frontend_model.svh"

	branch_frontend #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) DUT (
		.clk         (clk),
		.arst_n      (arst_n),
		.imem_req    (imem_req),
		.imem_addr   (imem_addr),
		.imem_data   (imem_data),
		.rd_sel      (rd_sel),
		.rd_data     (rd_data),
		.ra_we       (ra_we),
		.ra_data     (ra_data),
		.retire_valid(retire_valid),
		.retire_pc   (retire_pc),
		.retire_instr(retire_instr),
		.retire_ready(retire_ready),
		.redirect    (redirect),
		.redirect_pc (redirect_pc)
	);

	always #5 clk = ~clk;

	assign rd_data = regs[rd_sel];

	always @(posedge clk) begin
		if (imem_req) begin
			imem_data <= mem[imem_addr[5:0]];  // Memory wraps every 64 words
		end else begin
			imem_data <= 'x;  // No answer without a request
		end
		if (ra_we) begin
			regs[fe_pkg::REG_RA] <= ra_data;
		end
		if (backpressure) begin
			bp_word = lcg_next();
			retire_ready <= bp_word[31];
		end else begin
			retire_ready <= 1'b1;
		end
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic load_stimulus();
		logic [31:0] r;
		logic [2:0]  rx;
		int          a;
		int          off;
		for (a = 0; a < MEM_WORDS; a++) begin
			r   = lcg_next();
			rx  = r[8:6];
			off = int'(r[5:0]) - a - 1;  // Target stays inside memory
			case (r[31:16] % 12)
				4:  mem[a] = {fe_pkg::OP_B, 11'(off)};
				5:  mem[a] = {fe_pkg::OP_BEQZ, rx, 8'(off)};
				6:  mem[a] = {fe_pkg::OP_BNEZ, rx, 8'(off)};
				7:  mem[a] = {fe_pkg::OP_TBR, fe_pkg::TBR_EQZ, 8'(off)};
				8:  mem[a] = {fe_pkg::OP_TBR, fe_pkg::TBR_NEZ, 8'(off)};
				9:  mem[a] = {fe_pkg::OP_JREG, rx, fe_pkg::FN_JR};
				10: mem[a] = {fe_pkg::OP_JREG, rx, fe_pkg::FN_JALR};
				11: mem[a] = {fe_pkg::OP_JREG, fe_pkg::FN_JRRA};
				default: mem[a] = r[27:12];
			endcase
		end
		for (a = 0; a < 16; a++) begin
			r       = lcg_next();
			regs[a] = (a < 10 && r[31]) ? {10'd0, r[21:16]} : '0;
			m_regs[a] = regs[a];
		end
	endtask

	task automatic report_mismatch(input string what, input logic [fe_pkg::XLEN-1:0] got,
			input logic [fe_pkg::XLEN-1:0] exp);
		$display("[ERROR] %0t ns: %s is %h, expected %h at pc %h", $time, what, got, exp, m_pc);
		errors++;
	endtask

	// Called at the falling edge, outputs are settled here
	task automatic check_cycle();
		logic [fe_pkg::XLEN-1:0] word;
		logic [fe_pkg::XLEN-1:0] operand;
		logic [fe_pkg::XLEN-1:0] target;
		logic                    take;
		int                      kind;
		if (retire_valid && !prev_hold) begin
			word    = mem[m_pc[5:0]];
			kind    = decode_kind(word);
			operand = m_regs[operand_sel(kind, word)];
			take    = is_taken(kind, operand);
			target  = branch_target(kind, m_pc, word, operand);
			if (retire_pc !== m_pc) report_mismatch("retire_pc", retire_pc, m_pc);
			if (retire_instr !== word) report_mismatch("retire_instr", retire_instr, word);
			if (redirect !== take) begin
				report_mismatch("redirect", redirect, take);
			end else if (take && redirect_pc !== target) begin
				report_mismatch("redirect_pc", redirect_pc, target);
			end
			if (ra_we !== (kind == K_JALR)) begin
				report_mismatch("ra_we", ra_we, kind == K_JALR);
			end else if (ra_we && ra_data !== m_pc + 16'd1) begin
				report_mismatch("ra_data", ra_data, m_pc + 16'd1);
			end
			if (kind == K_JALR) begin
				m_regs[fe_pkg::REG_RA] = m_pc + 16'd1;
				ra_writes++;
			end
			redirects += int'(take);
			m_pc = take ? target : m_pc + 16'd1;
		end else if (redirect || ra_we) begin
			$display("[ERROR] %0t ns: redirect or RA write without a new retire", $time);
			errors++;
		end
		if (retire_valid && retire_ready) begin
			retired++;
		end
		prev_hold = retire_valid && !retire_ready;
	endtask

	task automatic run_stream(input int target_count);
		while (retired < target_count && cycles < CYCLE_LIMIT) begin
			@(negedge clk);
			cycles++;
			check_cycle();
		end
		if (retired < target_count) begin
			$display("Timeout: cycle limit of %0d reached after %0d retirements",
				CYCLE_LIMIT, retired);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors != errors_at_start) begin
			tests_failed++;
		end
		$display("Test %-24s %s (%0d errors)", name,
			(errors == errors_at_start) ? "ok" : "FAILED", errors - errors_at_start);
		errors_at_start = errors;
	endtask

	task automatic check_idle(input string when);
		if (imem_req !== 1'b0 || retire_valid !== 1'b0 || redirect !== 1'b0
				|| ra_we !== 1'b0) begin
			$display("[ERROR] %0t ns: outputs not idle %s", $time, when);
			errors++;
		end
	endtask

	initial begin
		clk             = 1'b0;
		arst_n          = 1'b0;
		retire_ready    = 1'b0;
		imem_data       = '0;
		backpressure    = 1'b0;
		prev_hold       = 1'b0;
		lcg_state       = 32'hca016b8f;
		m_pc            = '0;  // Architectural start
		cycles          = 0;
		retired         = 0;
		errors          = 0;
		errors_at_start = 0;
		tests_run       = 0;
		tests_failed    = 0;
		redirects       = 0;
		ra_writes       = 0;
		load_stimulus();

		repeat (8) @(posedge clk);
		check_idle("during reset");
		arst_n <= 1'b1;
		@(negedge clk);
		check_idle("after reset");
		end_test("reset_state");

		run_stream(HALF_RETIRES);
		end_test("stream_no_backpressure");

		backpressure = 1'b1;
		run_stream(ALL_RETIRES);
		end_test("stream_backpressure");

		if (retired != ALL_RETIRES) begin
			$display("Only %0d of %0d instructions retired", retired, ALL_RETIRES);
			errors++;
		end
		end_test("retire_count");

		$display("Tests %0d run, %0d failed; %0d retired, %0d redirects, %0d RA writes, %0d errors",
			tests_run, tests_failed, retired, redirects, ra_writes, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// ==== branch_frontend.f ====
+incdir+bench
rtl/fe_pkg.sv
rtl/fetch_unit.sv
rtl/fetch_queue.sv
rtl/branch_unit.sv
rtl/branch_frontend.sv
bench/tb_branch_frontend.sv

// ==== rtl/branch_frontend.sv ====
`timescale 1ns/1ps

module branch_frontend #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic                      clk,
	input  logic                      arst_n,
	output logic                      imem_req,
	output logic [fe_pkg::XLEN-1:0]   imem_addr,
	input  logic [fe_pkg::XLEN-1:0]   imem_data,
	output logic [fe_pkg::SEL_W-1:0]  rd_sel,
	input  logic [fe_pkg::XLEN-1:0]   rd_data,
	output logic                      ra_we,
	output logic [fe_pkg::XLEN-1:0]   ra_data,
	output logic                      retire_valid,
	output logic [fe_pkg::XLEN-1:0]   retire_pc,
	output logic [fe_pkg::XLEN-1:0]   retire_instr,
	input  logic                      retire_ready,
	output logic                      redirect,
	output logic [fe_pkg::XLEN-1:0]   redirect_pc
);

	logic                    push;
	logic [fe_pkg::XLEN-1:0] push_pc;
	logic [fe_pkg::XLEN-1:0] push_instr;
	logic                    credit_ret;
	logic                    head_valid;
	logic [fe_pkg::XLEN-1:0] head_pc;
	logic [fe_pkg::XLEN-1:0] head_instr;
	logic                    pop;

	fetch_unit #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) u_fetch (
		.clk        (clk),
		.arst_n     (arst_n),
		.imem_data  (imem_data),
		.credit_ret (credit_ret),
		.redirect   (redirect),
		.redirect_pc(redirect_pc),
		.imem_req   (imem_req),
		.imem_addr  (imem_addr),
		.push       (push),
		.push_pc    (push_pc),
		.push_instr (push_instr)
	);

	fetch_queue #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) u_queue (
		.clk        (clk),
		.arst_n     (arst_n),
		.push       (push),
		.push_pc    (push_pc),
		.push_instr (push_instr),
		.pop        (pop),
		.flush      (redirect),  // Redirect doubles as flush
		.head_valid (head_valid),
		.head_pc    (head_pc),
		.head_instr (head_instr),
		.credit_ret (credit_ret)
	);

	branch_unit u_branch (
		.clk         (clk),
		.arst_n      (arst_n),
		.head_valid  (head_valid),
		.head_pc     (head_pc),
		.head_instr  (head_instr),
		.rd_data     (rd_data),
		.retire_ready(retire_ready),
		.pop         (pop),
		.rd_sel      (rd_sel),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.ra_we       (ra_we),
		.ra_data     (ra_data),
		.retire_valid(retire_valid),
		.retire_pc   (retire_pc),
		.retire_instr(retire_instr)
	);

endmodule

// ==== rtl/branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      head_valid,
	input  logic [fe_pkg::XLEN-1:0]   head_pc,
	input  logic [fe_pkg::XLEN-1:0]   head_instr,
	input  logic [fe_pkg::XLEN-1:0]   rd_data,
	input  logic                      retire_ready,
	output logic                      pop,
	output logic [fe_pkg::SEL_W-1:0]  rd_sel,
	output logic                      redirect,
	output logic [fe_pkg::XLEN-1:0]   redirect_pc,
	output logic                      ra_we,
	output logic [fe_pkg::XLEN-1:0]   ra_data,
	output logic                      retire_valid,
	output logic [fe_pkg::XLEN-1:0]   retire_pc,
	output logic [fe_pkg::XLEN-1:0]   retire_instr
);

	fe_pkg::instr_u          ins;
	logic                    is_b;
	logic                    is_beqz;
	logic                    is_bnez;
	logic                    is_bteqz;
	logic                    is_btnez;
	logic                    is_jr;
	logic                    is_jalr;
	logic                    is_jrra;
	logic                    is_rjump;
	logic                    op_zero;
	logic                    taken;
	logic                    accept;
	logic [fe_pkg::XLEN-1:0] pc_inc;
	logic [fe_pkg::XLEN-1:0] target;

	assign ins = head_instr;

	always_comb begin
		is_b     = ins.lng.op == fe_pkg::OP_B;
		is_beqz  = ins.rbr.op == fe_pkg::OP_BEQZ;
		is_bnez  = ins.rbr.op == fe_pkg::OP_BNEZ;
		is_bteqz = (ins.rbr.op == fe_pkg::OP_TBR) && (ins.rbr.rx == fe_pkg::TBR_EQZ);
		is_btnez = (ins.rbr.op == fe_pkg::OP_TBR) && (ins.rbr.rx == fe_pkg::TBR_NEZ);
		is_jr    = (ins.rjmp.op == fe_pkg::OP_JREG) && (ins.rjmp.funct11[7:0] == fe_pkg::FN_JR);
		is_jalr  = (ins.rjmp.op == fe_pkg::OP_JREG)
			&& (ins.rjmp.funct11[7:0] == fe_pkg::FN_JALR);
		is_jrra  = (ins.rjmp.op == fe_pkg::OP_JREG) && (ins.rjmp.funct11 == fe_pkg::FN_JRRA);
		is_rjump = is_jr || is_jalr || is_jrra;
	end

	// Operand select goes straight out, data returns this cycle
	always_comb begin
		if (is_beqz || is_bnez || is_jr || is_jalr) begin
			rd_sel = {1'b0, ins.rbr.rx};
		end else if (is_bteqz || is_btnez) begin
			rd_sel = fe_pkg::REG_T;
		end else if (is_jrra) begin
			rd_sel = fe_pkg::REG_RA;
		end else begin
			rd_sel = '0;
		end
	end

	assign op_zero = rd_data == '0;
	assign pc_inc  = head_pc + 1'b1;

	always_comb begin
		taken = is_b || is_rjump
			|| ((is_beqz || is_bteqz) && op_zero)
			|| ((is_bnez || is_btnez) && !op_zero);
		if (is_b) begin
			target = pc_inc + {{5{ins.lng.imm11[10]}}, ins.lng.imm11};
		end else if (is_rjump) begin
			target = rd_data;  // All register jumps share this rule
		end else begin
			target = pc_inc + {{8{ins.rbr.imm8[7]}}, ins.rbr.imm8};
		end
	end

	// Hold off while the retire slot is stuck or a flush is under way
	assign accept = head_valid && (!retire_valid || retire_ready) && !redirect;
	assign pop    = accept;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			redirect     <= 1'b0;
			ra_we        <= 1'b0;
			retire_valid <= 1'b0;
		end else begin
			redirect <= accept && taken;
			ra_we    <= accept && is_jalr;
			if (accept) begin
				retire_valid <= 1'b1;
			end else if (retire_ready) begin
				retire_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			redirect_pc  <= target;
			ra_data      <= pc_inc;  // Return address for JALR
			retire_pc    <= head_pc;
			retire_instr <= head_instr;
		end
	end

	a_ra_with_redirect: assert property (@(posedge clk) disable iff (!arst_n)
		ra_we |-> redirect)
		else $error("branch_unit: RA write without redirect");

endmodule

// ==== rtl/fe_pkg.sv ====
package fe_pkg;

	localparam int XLEN  = 16;
	localparam int SEL_W = 4;

	// Register selects beyond the eight general registers
	localparam logic [SEL_W-1:0] REG_T  = 4'd8;
	localparam logic [SEL_W-1:0] REG_RA = 4'd9;

	// Major opcodes, bits 15 to 11
	localparam logic [4:0] OP_B    = 5'b00010;
	localparam logic [4:0] OP_BEQZ = 5'b00100;
	localparam logic [4:0] OP_BNEZ = 5'b00101;
	localparam logic [4:0] OP_TBR  = 5'b01100;
	localparam logic [4:0] OP_JREG = 5'b11101;

	// T-register branch kind, bits 10 to 8
	localparam logic [2:0] TBR_EQZ = 3'b000;
	localparam logic [2:0] TBR_NEZ = 3'b001;

	// Register jump functions
	localparam logic [7:0]  FN_JR   = 8'b00000000;  // Low eight bits
	localparam logic [7:0]  FN_JALR = 8'b11000000;  // Low eight bits
	localparam logic [10:0] FN_JRRA = 11'b00000100000;  // Low eleven bits

	typedef union packed {
		struct packed {
			logic [4:0]  op;
			logic [10:0] imm11;
		} lng;  // B
		struct packed {
			logic [4:0] op;
			logic [2:0] rx;
			logic [7:0] imm8;
		} rbr;  // BEQZ, BNEZ, BTEQZ, BTNEZ
		struct packed {
			logic [4:0]  op;
			logic [10:0] funct11;
		} rjmp;  // JR, JALR, JRRA
	} instr_u;

endpackage

// ==== rtl/fetch_queue.sv ====
`timescale 1ns/1ps

module fetch_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     push,
	input  logic [fe_pkg::XLEN-1:0]  push_pc,
	input  logic [fe_pkg::XLEN-1:0]  push_instr,
	input  logic                     pop,
	input  logic                     flush,
	output logic                     head_valid,
	output logic [fe_pkg::XLEN-1:0]  head_pc,
	output logic [fe_pkg::XLEN-1:0]  head_instr,
	output logic                     credit_ret
);

	localparam int PTR_W = $clog2(QUEUE_DEPTH);
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST = PTR_W'(QUEUE_DEPTH - 1);

	logic [fe_pkg::XLEN-1:0] pc_mem    [QUEUE_DEPTH];
	logic [fe_pkg::XLEN-1:0] instr_mem [QUEUE_DEPTH];
	logic [PTR_W-1:0]        wr_ptr;
	logic [PTR_W-1:0]        rd_ptr;
	logic [CNT_W-1:0]        count;
	logic                    do_push;
	logic                    do_pop;

	assign do_push = push && !flush;
	assign do_pop  = pop && !flush;

	assign head_valid = count != '0;
	assign head_pc    = pc_mem[rd_ptr];
	assign head_instr = instr_mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push) begin
			pc_mem[wr_ptr]    <= push_pc;
			instr_mem[wr_ptr] <= push_instr;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			credit_ret <= 1'b0;
		end else if (flush) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			credit_ret <= 1'b0;  // Fetch reloads its credits on flush
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
			end
			count      <= count + CNT_W'(do_push) - CNT_W'(do_pop);
			credit_ret <= do_pop;
		end
	end

	// Credit flow in fetch_unit must keep the queue from overflowing
	a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
		push && !flush |-> count != CNT_W'(QUEUE_DEPTH) || pop)
		else $error("fetch_queue: push into full queue");

	a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
		pop |-> head_valid)
		else $error("fetch_queue: pop from empty queue");

endmodule

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic [fe_pkg::XLEN-1:0]  imem_data,
	input  logic                     credit_ret,
	input  logic                     redirect,
	input  logic [fe_pkg::XLEN-1:0]  redirect_pc,
	output logic                     imem_req,
	output logic [fe_pkg::XLEN-1:0]  imem_addr,
	output logic                     push,
	output logic [fe_pkg::XLEN-1:0]  push_pc,
	output logic [fe_pkg::XLEN-1:0]  push_instr
);

	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
	localparam logic [CNT_W-1:0] FULL_CREDITS = CNT_W'(QUEUE_DEPTH);

	logic [fe_pkg::XLEN-1:0] pc;
	logic [CNT_W-1:0]        credits;
	logic                    run;  // Low only in the first cycle out of reset
	logic                    pend_valid;
	logic [fe_pkg::XLEN-1:0] pend_pc;

	// No request while a redirect is being applied
	assign imem_req  = run && (credits != '0) && !redirect;
	assign imem_addr = pc;

	// Memory answers one cycle after the request
	assign push       = pend_valid && !redirect;  // Stale if flushed meanwhile
	assign push_pc    = pend_pc;
	assign push_instr = imem_data;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			run <= 1'b0;
		end else begin
			run <= 1'b1;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= '0;
		end else if (redirect) begin
			pc <= redirect_pc;
		end else if (imem_req) begin
			pc <= pc + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			credits <= FULL_CREDITS;
		end else if (redirect) begin
			credits <= FULL_CREDITS;  // Queue flushed, nothing in flight
		end else begin
			credits <= credits + CNT_W'(credit_ret) - CNT_W'(imem_req);
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pend_valid <= 1'b0;
		end else begin
			pend_valid <= imem_req;
		end
	end

	always_ff @(posedge clk) begin
		if (imem_req) begin
			pend_pc <= pc;
		end
	end

	// Returned credits plus spent ones must balance against the queue size
	a_credit_bound: assert property (@(posedge clk) disable iff (!arst_n)
		credits <= FULL_CREDITS)
		else $error("fetch_unit: credit count above queue depth");

endmodule
